// ==== config.svh ====
// default clock and scan rates, included wherever the display parameters need defaults
`ifndef SEG_CONFIG_SVH
`define SEG_CONFIG_SVH

// board clock in MHz
`define SEG_CLK_MHZ 50

// per-digit refresh rate, high enough to hide the multiplexing
`define SEG_DIGIT_HZ 128

// how often the shown value may change
`define SEG_DATA_HZ 4

`endif

// ==== seg_pkg.sv ====
// shared types, register offsets and structs for the seven-segment AXI4-Lite display controller
`default_nettype none

package seg_pkg;

    typedef logic [3:0]  nibble_t;     // one hex digit
    typedef logic [7:0]  seg_t;        // segments a..h, a is the msb
    typedef logic [3:0]  axil_addr_t;  // byte offset inside the register window
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay   = 2'd0;
    localparam axil_resp_t resp_slverr = 2'd2;

    // register map, anything else is unmapped
    localparam axil_addr_t addr_number = 4'h0;
    localparam axil_addr_t addr_dots   = 4'h4;
    localparam axil_addr_t addr_blank  = 4'h8;

    // register contents handed to the scan engine
    typedef struct packed {
        axil_data_t number;  // digit 0 in the low nibble
        logic [7:0] dots;
        logic [7:0] blank;   // set bit turns the digit off
    } disp_cfg_t;

    // one digit request from the scan engine to the encoder
    typedef struct packed {
        nibble_t    nibble;
        logic       dot;
        logic       blank;
        logic [2:0] index;
    } seg_req_t;

    // write channel handling in the register block
    typedef enum logic {
        wr_idle,
        wr_resp  // response pending on B
    } wr_state_e;

endpackage

`default_nettype wire

// ==== seg_axil_regs.sv ====
// AXI4-Lite register block holding the number, dots and blank registers for the display
`timescale 1ns/1ps
`default_nettype none

module seg_axil_regs
#(
    parameter int w_digit = 4
)
(
    input  wire                   clk,
    input  wire                   rst,

    // write address
    input  wire                   awvalid,
    output logic                  awready,
    input  seg_pkg::axil_addr_t   awaddr,

    // write data
    input  wire                   wvalid,
    output logic                  wready,
    input  seg_pkg::axil_data_t   wdata,
    input  seg_pkg::axil_strb_t   wstrb,

    // write response
    output logic                  bvalid,
    input  wire                   bready,
    output seg_pkg::axil_resp_t   bresp,

    // read address
    input  wire                   arvalid,
    output logic                  arready,
    input  seg_pkg::axil_addr_t   araddr,

    // read data
    output logic                  rvalid,
    input  wire                   rready,
    output seg_pkg::axil_data_t   rdata,
    output seg_pkg::axil_resp_t   rresp,

    output seg_pkg::disp_cfg_t    cfg
);

    import seg_pkg::*;

    // only the bits of existing digits are kept in dots and blank
    localparam logic [7:0] digit_mask = 8'((1 << w_digit) - 1);

    wr_state_e  wr_state;

    logic       aw_held;   // address captured, waiting for data
    logic       w_held;    // data captured, waiting for address
    axil_addr_t aw_addr_q;
    axil_data_t w_data_q;
    axil_strb_t w_strb_q;

    axil_data_t number_q;
    logic [7:0] dots_q;
    logic [7:0] blank_q;

    logic       wr_fire;
    axil_data_t wr_merged;

    function automatic logic is_mapped(input axil_addr_t a);
        return a inside {addr_number, addr_dots, addr_blank};
    endfunction

    // register contents as seen on the bus, zero when unmapped
    function automatic axil_data_t reg_word(input axil_addr_t a);
        case (a)
            addr_number: return number_q;
            addr_dots:   return {24'b0, dots_q};
            addr_blank:  return {24'b0, blank_q};
            default:     return '0;
        endcase
    endfunction

    function automatic axil_data_t merge_bytes(
        input axil_data_t old_val,
        input axil_data_t new_val,
        input axil_strb_t strb
    );
        axil_data_t res;
        int         i;
        res = old_val;
        for (i = 0; i < 4; i++)
        begin
            if (strb[i])
                res[i * 8 +: 8] = new_val[i * 8 +: 8];
        end
        return res;
    endfunction

    assign awready = !aw_held && (wr_state == wr_idle);
    assign wready  = !w_held && (wr_state == wr_idle);
    assign bvalid  = (wr_state == wr_resp);
    assign arready = !rvalid;

    assign wr_fire   = aw_held && w_held && (wr_state == wr_idle);
    assign wr_merged = merge_bytes(reg_word(aw_addr_q), w_data_q, w_strb_q);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_state <= wr_idle;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            number_q <= '0;
            dots_q   <= '0;
            blank_q  <= '0;
        end
        else
        begin
            case (wr_state)
                wr_idle:
                begin
                    if (awvalid && awready)
                        aw_held <= 1'b1;
                    if (wvalid && wready)
                        w_held <= 1'b1;
                    if (wr_fire)
                    begin
                        aw_held  <= 1'b0;
                        w_held   <= 1'b0;
                        wr_state <= wr_resp;
                        case (aw_addr_q)
                            addr_number: number_q <= wr_merged;
                            addr_dots:   dots_q   <= wr_merged[7:0] & digit_mask;
                            addr_blank:  blank_q  <= wr_merged[7:0] & digit_mask;
                            default:     ;  // unmapped, nothing changes
                        endcase
                    end
                end
                wr_resp:
                begin
                    if (bready)
                        wr_state <= wr_idle;
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rvalid <= 1'b0;
        else if (rvalid && rready)
            rvalid <= 1'b0;
        else if (arvalid && arready)
            rvalid <= 1'b1;
    end

    // captured payloads and responses
    always_ff @(posedge clk)
    begin
        if (awvalid && awready)
            aw_addr_q <= awaddr;
        if (wvalid && wready)
        begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (wr_fire)
            bresp <= is_mapped(aw_addr_q) ? resp_okay : resp_slverr;
        if (arvalid && arready)
        begin
            rdata <= reg_word(araddr);
            rresp <= is_mapped(araddr) ? resp_okay : resp_slverr;
        end
    end

    assign cfg = '{number: number_q, dots: dots_q, blank: blank_q};

endmodule

`default_nettype wire

// ==== seven_segment_display.sv ====
// scan engine that walks the digits and snapshots the registers at a slower data rate
`timescale 1ns/1ps
`default_nettype none

module seven_segment_display
#(
    parameter int w_digit         = 4,
    parameter int clk_mhz         = 50,
    parameter int digit_update_hz = 128,  // per-digit rate, keep it high against flicker
    parameter int data_update_hz  = 4     // how often a new value is taken
)
(
    input  wire                 clk,
    input  wire                 rst,

    input  seg_pkg::disp_cfg_t  cfg,

    output seg_pkg::seg_req_t   req,
    output logic                req_valid  // one cycle at the end of each slot
);

    import seg_pkg::*;

    // cycles per digit slot, minus one
    localparam int slot_max = clk_mhz * 1000000 / w_digit / digit_update_hz;
    localparam int w_slot   = slot_max > 0 ? $clog2(slot_max + 1) : 1;

    // frames between snapshots, minus one
    localparam int frame_max = digit_update_hz / data_update_hz;
    localparam int w_frame   = frame_max > 0 ? $clog2(frame_max + 1) : 1;

    localparam logic [2:0] last_index = 3'(w_digit - 1);

    logic [w_slot - 1:0]  slot_cnt;
    logic [w_frame - 1:0] frame_cnt;
    logic [2:0]           index;
    disp_cfg_t            snap;   // value currently on the display

    logic slot_end;
    logic frame_end;
    logic data_end;

    assign slot_end  = (slot_cnt == w_slot'(slot_max));
    assign frame_end = slot_end && (index == last_index);
    assign data_end  = frame_end && (frame_cnt == w_frame'(frame_max));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            slot_cnt  <= '0;
            frame_cnt <= '0;
            index     <= '0;
            snap      <= '0;
        end
        else
        begin
            if (slot_end)
                slot_cnt <= '0;
            else
                slot_cnt <= slot_cnt + 1'b1;

            if (frame_end)
                index <= '0;
            else if (slot_end)
                index <= index + 3'd1;

            if (data_end)
            begin
                frame_cnt <= '0;
                snap      <= cfg;   // new frame starts with the fresh value
            end
            else if (frame_end)
            begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    assign req_valid = slot_end;

    assign req = '{
        nibble: snap.number[index * 4 +: 4],
        dot:    snap.dots[index],
        blank:  snap.blank[index],
        index:  index
    };

endmodule

`default_nettype wire

// ==== seg_encoder.sv ====
// registered hex-to-segment encoder with dot, blanking and one-hot digit select
`timescale 1ns/1ps
`default_nettype none

module seg_encoder
#(
    parameter int w_digit = 4
)
(
    input  wire                 clk,
    input  wire                 rst,

    input  seg_pkg::seg_req_t   req,
    input  wire                 req_valid,

    output seg_pkg::seg_t       abcdefgh,
    output logic [w_digit - 1:0] digit
);

    import seg_pkg::*;

    // segment bits are a b c d e f g h, h is the dot
    function automatic seg_t hex_to_seg(input nibble_t n);
        case (n)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1110_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;  // lower case b
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;  // lower case d
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;  // F
        endcase
    endfunction

    seg_t seg_next;

    always_comb
    begin
        seg_next = hex_to_seg(req.nibble) ^ {7'b0, req.dot};
        if (req.blank)
            seg_next = '0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            abcdefgh <= '0;
            digit    <= '0;  // nothing lit until the first slot
        end
        else if (req_valid)
        begin
            abcdefgh <= seg_next;
            digit    <= w_digit'(1) << req.index;
        end
    end

endmodule

`default_nettype wire

// ==== seg_display_top.sv ====
// top level of the display controller, AXI4-Lite in and segment and digit lines out
`timescale 1ns/1ps
`default_nettype none

`include "config.svh"

module seg_display_top
#(
    parameter int w_digit         = 4,
    parameter int clk_mhz         = `SEG_CLK_MHZ,
    parameter int digit_update_hz = `SEG_DIGIT_HZ,
    parameter int data_update_hz  = `SEG_DATA_HZ
)
(
    input  wire                   clk,
    input  wire                   rst,

    input  wire                   awvalid,
    output logic                  awready,
    input  seg_pkg::axil_addr_t   awaddr,

    input  wire                   wvalid,
    output logic                  wready,
    input  seg_pkg::axil_data_t   wdata,
    input  seg_pkg::axil_strb_t   wstrb,

    output logic                  bvalid,
    input  wire                   bready,
    output seg_pkg::axil_resp_t   bresp,

    input  wire                   arvalid,
    output logic                  arready,
    input  seg_pkg::axil_addr_t   araddr,

    output logic                  rvalid,
    input  wire                   rready,
    output seg_pkg::axil_data_t   rdata,
    output seg_pkg::axil_resp_t   rresp,

    output seg_pkg::seg_t         abcdefgh,
    output logic [w_digit - 1:0]  digit
);

    import seg_pkg::*;

    disp_cfg_t cfg;
    seg_req_t  req;
    logic      req_valid;

    seg_axil_regs #(.w_digit(w_digit)) i_regs (
        .clk, .rst,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .cfg
    );

    seven_segment_display #(
        .w_digit         (w_digit),
        .clk_mhz         (clk_mhz),
        .digit_update_hz (digit_update_hz),
        .data_update_hz  (data_update_hz)
    ) i_scan (
        .clk, .rst,
        .cfg,
        .req, .req_valid
    );

    seg_encoder #(.w_digit(w_digit)) i_encoder (
        .clk, .rst,
        .req, .req_valid,
        .abcdefgh, .digit
    );

endmodule

`default_nettype wire

// ==== seg_display_assert.sv ====
// concurrent checks on AXI response stability and display outputs, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module seg_display_assert
#(
    parameter int w_digit = 4
)
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  bvalid,
    input  wire                  bready,
    input  seg_pkg::axil_resp_t  bresp,
    input  wire                  rvalid,
    input  wire                  rready,
    input  seg_pkg::axil_data_t  rdata,
    input  seg_pkg::seg_t        abcdefgh,
    input  wire [w_digit - 1:0]  digit
);

    // at most one digit lit at a time
    digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(digit))
        else $error("digit select has more than one bit set");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read data dropped or changed before rready");

    dark_when_idle: assert property (@(posedge clk) disable iff (rst)
        digit == '0 |-> abcdefgh == '0)
        else $error("segments lit with no digit selected");

endmodule

bind seg_display_top seg_display_assert #(.w_digit(w_digit)) i_assert (
    .clk      (clk),
    .rst      (rst),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .abcdefgh (abcdefgh),
    .digit    (digit)
);

`default_nettype wire

// ==== tb_seg_display.sv ====
// testbench for the display controller, random AXI4-Lite traffic checked against a register model
`timescale 1ns/1ps
`default_nettype none

module tb_seg_display;

    import seg_pkg::*;

    localparam int w_digit         = 4;
    localparam int clk_mhz         = 1;
    localparam int digit_update_hz = 100000;
    localparam int data_update_hz  = 25000;

    localparam int slot      = clk_mhz * 1000000 / w_digit / digit_update_hz + 1;  // cycles per digit
    localparam int frame     = slot * w_digit;
    localparam int data_per  = frame * (digit_update_hz / data_update_hz + 1);  // snapshot period
    localparam int n_iter    = 40;
    localparam int n_trans   = n_iter * 2 + n_iter / 10 * 3;
    localparam int scan_wait = 2 * data_per + 2 * frame + 2 * slot;
    localparam int timeout_cycles = 10 + n_trans * 40 + n_iter / 10 * scan_wait;

    localparam logic [7:0] digit_mask = 8'((1 << w_digit) - 1);

    // a..h from the msb, b and d are lower case
    localparam seg_t hex_table [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'he6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 awvalid, wvalid, bready, arvalid, rready;  // driven here
    logic                 awready, wready, bvalid, arready, rvalid;
    axil_addr_t           awaddr, araddr;
    axil_data_t           wdata, rdata;
    axil_strb_t           wstrb;
    axil_resp_t           bresp, rresp;
    seg_t                 abcdefgh;
    logic [w_digit - 1:0] digit;

    axil_data_t m_number;  // model registers
    logic [7:0] m_dots;
    logic [7:0] m_blank;

    seg_display_top #(
        .w_digit         (w_digit),
        .clk_mhz         (clk_mhz),
        .digit_update_hz (digit_update_hz),
        .data_update_hz  (data_update_hz)
    ) uut (
        .clk, .rst,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .abcdefgh, .digit
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic idle_cycles(input int max_cycles);
        int n;
        n = $urandom_range(max_cycles, 0);
        repeat (n) @(negedge clk);
    endtask

    function automatic axil_addr_t random_addr();
        case ($urandom_range(3, 0))
            0:       return addr_number;
            1:       return addr_dots;
            2:       return addr_blank;
            default: return 4'hc;  // unmapped
        endcase
    endfunction

    // updates the model and returns the response the write should get
    function automatic axil_resp_t model_write(input axil_addr_t addr, input axil_data_t data,
                                               input axil_strb_t strb);
        int b;
        case (addr)
            addr_number:
            begin
                for (b = 0; b < 4; b++)
                    if (strb[b])
                        m_number[b * 8 +: 8] = data[b * 8 +: 8];
                return resp_okay;
            end
            addr_dots:
            begin
                if (strb[0])
                    m_dots = data[7:0] & digit_mask;
                return resp_okay;
            end
            addr_blank:
            begin
                if (strb[0])
                    m_blank = data[7:0] & digit_mask;
                return resp_okay;
            end
            default: return resp_slverr;
        endcase
    endfunction

    function automatic seg_t expect_seg(input int idx);
        seg_t s;
        s = hex_table[m_number[idx * 4 +: 4]];
        if (m_dots[idx])
            s[0] = ~s[0];  // dot is segment h
        if (m_blank[idx])
            s = '0;
        return s;
    endfunction

    task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb);
        axil_resp_t exp_resp;
        axil_resp_t first_resp;
        int         stall;
        int         k;
        fork
            begin
                idle_cycles(3);
                awvalid = 1'b1;
                awaddr  = addr;
                while (!awready)
                    @(negedge clk);
                @(negedge clk);
                awvalid = 1'b0;
            end
            begin
                idle_cycles(3);
                wvalid = 1'b1;
                wdata  = data;
                wstrb  = strb;
                while (!wready)
                    @(negedge clk);
                @(negedge clk);
                wvalid = 1'b0;
            end
        join
        exp_resp = model_write(addr, data, strb);
        while (!bvalid)
            @(negedge clk);
        first_resp = bresp;
        check("bresp", 32'(bresp), 32'(exp_resp));
        stall = $urandom_range(3, 0);
        for (k = 0; k < stall; k++)
        begin
            @(negedge clk);  // response must sit still while bready is low
            check("bvalid", 32'(bvalid), 32'd1);
            check("bresp", 32'(bresp), 32'(first_resp));
            check("awready", 32'(awready), 32'd0);
            check("wready", 32'(wready), 32'd0);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr);
        axil_data_t exp_data;
        axil_resp_t exp_resp;
        int         stall;
        int         k;
        exp_resp = resp_okay;
        case (addr)
            addr_number: exp_data = m_number;
            addr_dots:   exp_data = {24'b0, m_dots};
            addr_blank:  exp_data = {24'b0, m_blank};
            default:
            begin
                exp_data = '0;
                exp_resp = resp_slverr;
            end
        endcase
        idle_cycles(3);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready)
            @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clk);
        stall = $urandom_range(3, 0);
        for (k = 0; k <= stall; k++)
        begin
            if (k > 0)
            begin
                @(negedge clk);
                check("rvalid", 32'(rvalid), 32'd1);  // held while rready is low
            end
            check("rdata", rdata, exp_data);
            check("rresp", 32'(rresp), 32'(exp_resp));
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // two data periods for the snapshot to settle, then two full frames
    task automatic check_display();
        logic [w_digit - 1:0] prev;
        int                   held;
        int                   changes;
        int                   idx;
        int                   prev_idx;
        repeat (2 * data_per) @(negedge clk);
        prev     = digit;
        held     = 0;
        changes  = 0;
        prev_idx = -1;
        while (changes < 2 * w_digit + 1)
        begin
            @(negedge clk);
            held++;
            if (digit !== prev)
            begin
                if (!$onehot(digit))
                    fail_run("digit select is not one-hot during the scan");
                idx = $clog2(digit);
                if (prev_idx >= 0)
                begin
                    check("digit index", 32'(idx), 32'((prev_idx + 1) % w_digit));
                    check("digit hold", 32'(held), 32'(slot));
                end
                check("abcdefgh", 32'(abcdefgh), 32'(expect_seg(idx)));
                prev     = digit;
                prev_idx = idx;
                held     = 0;
                changes++;
            end
            else if (held > slot)
            begin
                fail_run("digit select stayed on one digit longer than a slot");
            end
        end
    endtask

    initial
    begin
        int i;
        void'($urandom(32'h782));
        rst      = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        m_number = '0;
        m_dots   = '0;
        m_blank  = '0;
        for (i = 0; i < 6; i++)  // five reset cycles and the first one after
        begin
            @(negedge clk);
            rst = (i < 4);
            check("bvalid", 32'(bvalid), 32'd0);
            check("rvalid", 32'(rvalid), 32'd0);
            check("awready", 32'(awready), 32'd1);
            check("wready", 32'(wready), 32'd1);
            check("arready", 32'(arready), 32'd1);
            check("digit", 32'(digit), 32'd0);
            check("abcdefgh", 32'(abcdefgh), 32'd0);
        end
        for (i = 0; i < n_iter; i++)
        begin
            axi_write(random_addr(), $urandom, 4'($urandom_range(15, 0)));
            axi_read(random_addr());
            if (i % 10 == 9)
            begin
                axi_read(addr_number);
                axi_read(addr_dots);
                axi_read(addr_blank);
                check_display();
            end
        end
        $display("No errors");
        $finish;
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        fail_run("timeout, the DUT stopped answering the bus or the scan stalled");
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
seg_pkg.sv
seg_axil_regs.sv
seven_segment_display.sv
seg_encoder.sv
seg_display_top.sv
seg_display_assert.sv
tb_seg_display.sv

// ==== Makefile ====
# Verilator build and run of the display controller testbench
TOP = tb_seg_display

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir \
		--top-module $(TOP) -f src.f

# passes only when the pass line shows up in the simulation output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "No errors" > /dev/null

clean:
	rm -rf obj_dir
